//--- src.f
hw/rename_pkg.sv
hw/reorder_buffer.sv
hw/free_list.sv
hw/map_table.sv
hw/arch_map.sv
hw/rename_core.sv
verif/rename_core_properties.sv
verif/rename_core_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module rename_core_tb \
  --Mdir obj_dir -o rename_core_sim \
  -f src.f

./obj_dir/rename_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "all tests passed" sim.log; then
  echo "simulation PASSED"
else
  echo "simulation FAILED"
  exit 1
fi

//--- verif/rename_core_tb.sv
`timescale 1ns/10ps

module rename_core_tb;

  import rename_pkg::*;

  localparam int          clock_period = 100;
  localparam int          num_pairs    = 300;
  localparam logic [31:0] lfsr_seed    = 32'hf2ac5e02;
  localparam logic [31:0] lfsr_taps    = 32'h80200003;

  logic                           clock;
  logic                           reset;
  logic                           dispatch_valid;
  dispatch_inst_t [num_super-1:0] dispatch_inst;
  logic [num_super-1:0]           complete_en;
  rob_idx_t [num_super-1:0]       complete_idx;
  logic                           rollback_en;
  rob_idx_t                       rollback_idx;
  logic                           dispatch_ready;
  rename_t [num_super-1:0]        rename_out;
  rob_idx_t [num_super-1:0]       dispatch_idx;
  logic [num_super-1:0]           retire_en;
  retire_t [num_super-1:0]        retire_out;
  logic                           is_halted;

  // reference model, queue front is the rob head
  retire_t             q_ent[$];
  bit                  q_done[$];
  rob_idx_t            m_head;
  rob_state_t          m_state;
  logic [num_phys-1:0] m_free;
  arch_table_t         m_spec;
  arch_table_t         m_arch;

  // expectations for the current cycle
  logic [num_super-1:0]      exp_retire;
  phys_tag_t [num_super-1:0] exp_tag;
  phys_tag_t [num_super-1:0] exp_told;
  logic                      accept;

  logic [31:0] lfsr_state;
  bit          pending;
  bit          halt_sent;
  int          pairs_sent;
  int          rollbacks;
  int          stalls;

  rename_core dut0 (
    .clock         (clock),
    .reset         (reset),
    .dispatch_valid(dispatch_valid),
    .dispatch_inst (dispatch_inst),
    .complete_en   (complete_en),
    .complete_idx  (complete_idx),
    .rollback_en   (rollback_en),
    .rollback_idx  (rollback_idx),
    .dispatch_ready(dispatch_ready),
    .rename_out    (rename_out),
    .dispatch_idx  (dispatch_idx),
    .retire_en     (retire_en),
    .retire_out    (retire_out),
    .halted        (is_halted)
  );

  bind rename_core rename_core_properties props0 (
    .clock         (clock),
    .reset         (reset),
    .dispatch_ready(dispatch_ready),
    .rollback_en   (rollback_en),
    .retire_en     (retire_en)
  );

  initial clock = 1'b0;
  always #(clock_period / 2) clock = ~clock;

  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_tag(string name, phys_tag_t expected, phys_tag_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_idx(string name, rob_idx_t expected, rob_idx_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_retire(string name, retire_t expected, retire_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual);
      abort_run();
    end
  endtask

  // one lfsr step per bit
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
    end
    return value;
  endfunction

  function automatic phys_tag_t lowest_free(logic [num_phys-1:0] bits);
    phys_tag_t tag;
    bit        found;
    tag   = '0;
    found = 1'b0;
    for (int t = 0; t < num_phys; t++) begin
      if (bits[t] && !found) begin
        tag   = phys_tag_t'(t);
        found = 1'b1;
      end
    end
    return tag;
  endfunction

  // free set after recovery
  function automatic logic [num_phys-1:0] unmapped_tags(arch_table_t map);
    logic [num_phys-1:0] bits;
    bits = '1;
    for (int r = 0; r < num_arch; r++) begin
      bits[map[r]] = 1'b0;
    end
    return bits;
  endfunction

  task automatic reset_model();
    q_ent.delete();
    q_done.delete();
    m_head  = '0;
    m_state = running;
    m_free  = '0;
    for (int t = num_arch; t < num_phys; t++) begin
      m_free[t] = 1'b1;
    end
    for (int r = 0; r < num_arch; r++) begin
      m_spec[r] = phys_tag_t'(r);
      m_arch[r] = phys_tag_t'(r);
    end
  endtask

  task automatic drive_inputs();
    int size;
    int pick;
    size = q_ent.size();
    if (!pending && pairs_sent < num_pairs && take_bits(2) != 0) begin
      dispatch_inst[0] = '{dest: arch_reg_t'(take_bits(5)), halt: 1'b0};
      // same dest now and then, to hit forwarding
      if (take_bits(2) == 0) begin
        dispatch_inst[1] = '{dest: dispatch_inst[0].dest, halt: 1'b0};
      end else begin
        dispatch_inst[1] = '{dest: arch_reg_t'(take_bits(5)), halt: 1'b0};
      end
      pending = 1'b1;
    end else if (!pending && pairs_sent == num_pairs && !halt_sent) begin
      dispatch_inst[0] = '{dest: arch_reg_t'(take_bits(5)), halt: 1'b0};
      dispatch_inst[1] = '{dest: arch_reg_t'(take_bits(5)), halt: 1'b1};
      pending   = 1'b1;
      halt_sent = 1'b1;
    end
    dispatch_valid = pending;
    for (int c = 0; c < num_super; c++) begin
      complete_en[c]  = 1'b0;
      complete_idx[c] = '0;
      if (size > 0 && take_bits(1) == 1) begin
        pick = int'(take_bits(4)) % size;
        if (!q_done[pick]) begin
          complete_en[c]  = 1'b1;
          complete_idx[c] = m_head + rob_idx_t'(pick);
        end
      end
    end
    rollback_en  = 1'b0;
    rollback_idx = '0;
    if (m_state == running && size > 0 && !halt_sent && take_bits(5) == 0) begin
      rollback_en  = 1'b1;
      rollback_idx = m_head + rob_idx_t'(int'(take_bits(4)) % size);
    end
  endtask

  task automatic check_outputs();
    int                  size;
    logic                exp_ready;
    logic [num_phys-1:0] rest;
    size      = q_ent.size();
    exp_ready = (m_state == running) && (size <= num_rob - 2) &&
                ($countones(m_free) >= 2) && !rollback_en;
    check_bit("dispatch_ready", exp_ready, dispatch_ready);
    check_bit("halted", m_state == rename_pkg::halted, is_halted);
    exp_retire[0] = (size >= 1) && q_done[0] && !rollback_en;
    exp_retire[1] = exp_retire[0] && (size >= 2) && q_done[1];
    check_bit("retire_en[0]", exp_retire[0], retire_en[0]);
    check_bit("retire_en[1]", exp_retire[1], retire_en[1]);
    for (int s = 0; s < num_super; s++) begin
      if (exp_retire[s]) begin
        check_retire($sformatf("retire_out[%0d]", s), q_ent[s], retire_out[s]);
      end
    end
    if (pending && m_state == running && !rollback_en && !exp_ready) begin
      stalls++;
    end
    accept = pending && exp_ready;
    if (accept) begin
      exp_tag[0] = lowest_free(m_free);
      rest = m_free;
      rest[exp_tag[0]] = 1'b0;
      exp_tag[1] = lowest_free(rest);
      exp_told[0] = m_spec[dispatch_inst[0].dest];
      exp_told[1] = (dispatch_inst[1].dest == dispatch_inst[0].dest) ? exp_tag[0] :
                    m_spec[dispatch_inst[1].dest];
      for (int s = 0; s < num_super; s++) begin
        check_tag($sformatf("rename_out[%0d].tag", s), exp_tag[s], rename_out[s].tag);
        check_tag($sformatf("rename_out[%0d].told", s), exp_told[s], rename_out[s].told);
        check_idx($sformatf("dispatch_idx[%0d]", s), m_head + rob_idx_t'(size + s),
                  dispatch_idx[s]);
      end
    end
  endtask

  // effects of the coming clock edge
  task automatic update_model();
    int      size;
    int      off;
    bit      recover_now;
    bit      halt_retired;
    retire_t ent;
    size         = q_ent.size();
    recover_now  = (m_state == recovering) && (size == 0);
    halt_retired = 1'b0;
    for (int c = 0; c < num_super; c++) begin
      if (complete_en[c]) begin
        off = int'(rob_idx_t'(complete_idx[c] - m_head));
        if (off < size) begin
          q_done[off] = 1'b1;
        end
      end
    end
    if (rollback_en) begin
      off = int'(rob_idx_t'(rollback_idx - m_head));
      while (q_ent.size() > off + 1) begin
        void'(q_ent.pop_back());
        void'(q_done.pop_back());
      end
    end
    for (int s = 0; s < num_super; s++) begin
      if (exp_retire[s]) begin
        ent = q_ent.pop_front();
        void'(q_done.pop_front());
        m_arch[ent.dest] = ent.tag;
        m_free[ent.told] = 1'b1;
        halt_retired     = halt_retired || ent.halt;
        m_head           = m_head + rob_idx_t'(1);
      end
    end
    if (accept) begin
      for (int s = 0; s < num_super; s++) begin
        m_spec[dispatch_inst[s].dest] = exp_tag[s];
        m_free[exp_tag[s]]            = 1'b0;
        q_ent.push_back('{dest: dispatch_inst[s].dest, tag: exp_tag[s],
                          told: exp_told[s], halt: dispatch_inst[s].halt});
        q_done.push_back(dispatch_inst[s].halt);
      end
      pending = 1'b0;
      pairs_sent++;
    end
    if (halt_retired) begin
      m_state = rename_pkg::halted;
    end else if (m_state == running && rollback_en) begin
      m_state = recovering;
      rollbacks++;
    end else if (recover_now) begin
      m_state = running;
      m_spec  = m_arch;
      m_free  = unmapped_tags(m_arch);
    end
  endtask

  task automatic run_cycle();
    drive_inputs();
    #(clock_period / 2 - 1);
    check_outputs();
    update_model();
    @(posedge clock);
    #1;
  endtask

  initial begin
    #(num_pairs * 200 * clock_period);
    $display("timeout: the DUT did not reach halt within the time limit");
    abort_run();
  end

  initial begin
    lfsr_state     = lfsr_seed;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_inst  = '0;
    complete_en    = '0;
    complete_idx   = '0;
    rollback_en    = 1'b0;
    rollback_idx   = '0;
    pending        = 1'b0;
    halt_sent      = 1'b0;
    pairs_sent     = 0;
    rollbacks      = 0;
    stalls         = 0;
    reset_model();
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;
    while (m_state != rename_pkg::halted) begin
      run_cycle();
    end
    // dispatch must stay closed once halted
    repeat (8) run_cycle();
    if (rollbacks > 0 && stalls > 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("run ended without any rollback or back-pressure cycle");
      abort_run();
    end
  end

endmodule

//--- verif/rename_core_properties.sv
`timescale 1ns/10ps

module rename_core_properties (
  input logic                             clock,
  input logic                             reset,
  input logic                             dispatch_ready,
  input logic                             rollback_en,
  input logic [rename_pkg::num_super-1:0] retire_en
);

  // second slot only retires behind the first
  retire_pair_order: assert property (
    @(posedge clock) disable iff (reset) retire_en[1] |-> retire_en[0]
  ) else $error("retire_en[1] high while retire_en[0] is low");

  no_dispatch_on_rollback: assert property (
    @(posedge clock) disable iff (reset) rollback_en |-> !dispatch_ready
  ) else $error("dispatch_ready high during rollback");

  // empty buffer right after reset
  quiet_after_reset: assert property (
    @(posedge clock) $fell(reset) |-> (retire_en == '0)
  ) else $error("retire_en nonzero in the first cycle after reset");

endmodule

//--- hw/rename_core.sv
`timescale 1ns/10ps

module rename_core (
  input  logic                                                  clock,
  input  logic                                                  reset,
  input  logic                                                  dispatch_valid,
  input  rename_pkg::dispatch_inst_t [rename_pkg::num_super-1:0] dispatch_inst,
  input  logic [rename_pkg::num_super-1:0]                      complete_en,
  input  rename_pkg::rob_idx_t [rename_pkg::num_super-1:0]      complete_idx,
  input  logic                                                  rollback_en,
  input  rename_pkg::rob_idx_t                                  rollback_idx,
  output logic                                                  dispatch_ready,
  output rename_pkg::rename_t [rename_pkg::num_super-1:0]       rename_out,
  output rename_pkg::rob_idx_t [rename_pkg::num_super-1:0]      dispatch_idx,
  output logic [rename_pkg::num_super-1:0]                      retire_en,
  output rename_pkg::retire_t [rename_pkg::num_super-1:0]       retire_out,
  output logic                                                  halted
);

  import rename_pkg::*;

  logic                            tags_available;
  logic                            alloc;
  logic                            recover;
  phys_tag_t [num_super-1:0]       alloc_tags;
  phys_tag_t [num_super-1:0]       told;
  phys_tag_t [num_super-1:0]       release_tags;
  arch_table_t                     arch_table;

  for (genvar s = 0; s < num_super; s++) begin : g_slot
    assign rename_out[s]   = '{tag: alloc_tags[s], told: told[s]};
    assign release_tags[s] = retire_out[s].told;
  end

  reorder_buffer rob0 (
    .clock         (clock),
    .reset         (reset),
    .dispatch_valid(dispatch_valid),
    .inst          (dispatch_inst),
    .renamed       (rename_out),
    .tags_available(tags_available),
    .complete_en   (complete_en),
    .complete_idx  (complete_idx),
    .rollback_en   (rollback_en),
    .rollback_idx  (rollback_idx),
    .dispatch_ready(dispatch_ready),
    .alloc         (alloc),
    .dispatch_idx  (dispatch_idx),
    .retire_en     (retire_en),
    .retire_out    (retire_out),
    .recover       (recover),
    .halted        (halted)
  );

  free_list fl0 (
    .clock         (clock),
    .reset         (reset),
    .alloc_en      (alloc),
    .release_en    (retire_en),
    .release_tags  (release_tags),
    .recover       (recover),
    .arch_table    (arch_table),
    .alloc_tags    (alloc_tags),
    .tags_available(tags_available)
  );

  map_table mt0 (
    .clock     (clock),
    .reset     (reset),
    .write_en  (alloc),
    .inst      (dispatch_inst),
    .new_tags  (alloc_tags),
    .recover   (recover),
    .arch_table(arch_table),
    .told      (told)
  );

  arch_map am0 (
    .clock     (clock),
    .reset     (reset),
    .retire_en (retire_en),
    .retire_out(retire_out),
    .arch_table(arch_table)
  );

endmodule

//--- hw/arch_map.sv
`timescale 1ns/10ps

module arch_map (
  input  logic                                            clock,
  input  logic                                            reset,
  input  logic [rename_pkg::num_super-1:0]                retire_en,
  input  rename_pkg::retire_t [rename_pkg::num_super-1:0] retire_out,
  output rename_pkg::arch_table_t                         arch_table
);

  import rename_pkg::*;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < num_arch; r++) begin
        arch_table[r] <= phys_tag_t'(r);
      end
    end else begin
      // slot order, so the younger retire wins
      for (int s = 0; s < num_super; s++) begin
        if (retire_en[s]) begin
          arch_table[retire_out[s].dest] <= retire_out[s].tag;
        end
      end
    end
  end

endmodule

//--- hw/map_table.sv
`timescale 1ns/10ps

module map_table (
  input  logic                                                  clock,
  input  logic                                                  reset,
  input  logic                                                  write_en,
  input  rename_pkg::dispatch_inst_t [rename_pkg::num_super-1:0] inst,
  input  rename_pkg::phys_tag_t [rename_pkg::num_super-1:0]     new_tags,
  input  logic                                                  recover,
  input  rename_pkg::arch_table_t                               arch_table,
  output rename_pkg::phys_tag_t [rename_pkg::num_super-1:0]     told
);

  import rename_pkg::*;

  arch_table_t spec_map;

  assign told[0] = spec_map[inst[0].dest];

  // slot 1 sees the older slot's new mapping first
  assign told[1] = (inst[1].dest == inst[0].dest) ? new_tags[0] :
                   spec_map[inst[1].dest];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < num_arch; r++) begin
        spec_map[r] <= phys_tag_t'(r);
      end
    end else if (recover) begin
      spec_map <= arch_table;
    end else if (write_en) begin
      spec_map[inst[0].dest] <= new_tags[0];
      // later write wins on a shared dest
      spec_map[inst[1].dest] <= new_tags[1];
    end
  end

endmodule

//--- hw/free_list.sv
`timescale 1ns/10ps

module free_list (
  input  logic                                              clock,
  input  logic                                              reset,
  input  logic                                              alloc_en,
  input  logic [rename_pkg::num_super-1:0]                  release_en,
  input  rename_pkg::phys_tag_t [rename_pkg::num_super-1:0] release_tags,
  input  logic                                              recover,
  input  rename_pkg::arch_table_t                           arch_table,
  output rename_pkg::phys_tag_t [rename_pkg::num_super-1:0] alloc_tags,
  output logic                                              tags_available
);

  import rename_pkg::*;

  logic [num_phys-1:0] free;
  logic [num_phys-1:0] in_use;
  logic                have_lo;
  logic                have_hi;

  // scan downward so the two lowest free tags end up in slots 0 and 1
  always_comb begin
    alloc_tags = '0;
    have_lo    = 1'b0;
    have_hi    = 1'b0;
    for (int t = num_phys - 1; t >= 0; t--) begin
      if (free[t]) begin
        alloc_tags[1] = alloc_tags[0];
        alloc_tags[0] = phys_tag_t'(t);
        have_hi       = have_lo;
        have_lo       = 1'b1;
      end
    end
  end

  assign tags_available = have_hi;

  // tags held by the committed map
  always_comb begin
    in_use = '0;
    for (int r = 0; r < num_arch; r++) begin
      in_use[arch_table[r]] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      free <= {{(num_phys - num_arch){1'b1}}, {num_arch{1'b0}}};
    end else if (recover) begin
      free <= ~in_use;
    end else begin
      if (alloc_en) begin
        free[alloc_tags[0]] <= 1'b0;
        free[alloc_tags[1]] <= 1'b0;
      end
      for (int s = 0; s < num_super; s++) begin
        if (release_en[s]) begin
          free[release_tags[s]] <= 1'b1;
        end
      end
    end
  end

endmodule

//--- hw/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer (
  input  logic                                                clock,
  input  logic                                                reset,
  input  logic                                                dispatch_valid,
  input  rename_pkg::dispatch_inst_t [rename_pkg::num_super-1:0] inst,
  input  rename_pkg::rename_t [rename_pkg::num_super-1:0]     renamed,
  input  logic                                                tags_available,
  input  logic [rename_pkg::num_super-1:0]                    complete_en,
  input  rename_pkg::rob_idx_t [rename_pkg::num_super-1:0]    complete_idx,
  input  logic                                                rollback_en,
  input  rename_pkg::rob_idx_t                                rollback_idx,
  output logic                                                dispatch_ready,
  output logic                                                alloc,
  output rename_pkg::rob_idx_t [rename_pkg::num_super-1:0]    dispatch_idx,
  output logic [rename_pkg::num_super-1:0]                    retire_en,
  output rename_pkg::retire_t [rename_pkg::num_super-1:0]     retire_out,
  output logic                                                recover,
  output logic                                                halted
);

  import rename_pkg::*;

  retire_t            entries [num_rob];
  logic [num_rob-1:0] valid;
  logic [num_rob-1:0] complete;
  logic [num_rob-1:0] squash;
  rob_idx_t           head;
  rob_idx_t           tail;
  rob_idx_t           head_1;
  rob_idx_t           tail_1;
  rob_idx_t           rb_age;
  rob_state_t         state;
  rob_state_t         state_next;
  logic               empty;
  logic               halt_retire;

  assign head_1 = head + rob_idx_t'(1);
  assign tail_1 = tail + rob_idx_t'(1);

  // head == tail is also the full case, so look at the valid bit
  assign empty = (head == tail) && !valid[head];

  assign dispatch_ready = !valid[tail] && !valid[tail_1] && tags_available &&
                          (state == running) && !rollback_en;
  assign alloc = dispatch_valid && dispatch_ready;

  assign dispatch_idx[0] = tail;
  assign dispatch_idx[1] = tail_1;

  // in-order retire from head
  assign retire_out[0] = entries[head];
  assign retire_out[1] = entries[head_1];
  assign retire_en[0]  = valid[head] && complete[head] && !rollback_en;
  assign retire_en[1]  = retire_en[0] && valid[head_1] && complete[head_1];

  assign halt_retire = (retire_en[0] && entries[head].halt) ||
                       (retire_en[1] && entries[head_1].halt);

  assign recover = (state == recovering) && empty;
  assign halted  = (state == rename_pkg::halted);

  // age of the branch relative to head
  assign rb_age = rollback_idx - head;

  always_comb begin
    for (int i = 0; i < num_rob; i++) begin
      squash[i] = rollback_en && ((rob_idx_t'(i) - head) > rb_age);
    end
  end

  always_comb begin
    state_next = state;
    if (halt_retire) begin
      state_next = rename_pkg::halted;
    end else begin
      case (state)
        running: begin
          if (rollback_en) begin
            state_next = recovering;
          end
        end
        recovering: begin
          // maps get restored on this edge
          if (recover) begin
            state_next = running;
          end
        end
        default: begin
          state_next = state;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= running;
      head     <= '0;
      tail     <= '0;
      valid    <= '0;
      complete <= '0;
    end else begin
      state <= state_next;
      for (int c = 0; c < num_super; c++) begin
        if (complete_en[c]) begin
          complete[complete_idx[c]] <= 1'b1;
        end
      end
      if (retire_en[1]) begin
        valid[head]   <= 1'b0;
        valid[head_1] <= 1'b0;
        head          <= head + rob_idx_t'(2);
      end else if (retire_en[0]) begin
        valid[head] <= 1'b0;
        head        <= head_1;
      end
      if (alloc) begin
        valid[tail]      <= 1'b1;
        valid[tail_1]    <= 1'b1;
        // halts need no execution
        complete[tail]   <= inst[0].halt;
        complete[tail_1] <= inst[1].halt;
        tail             <= tail + rob_idx_t'(2);
      end
      // never together with retire or alloc
      if (rollback_en) begin
        valid <= valid & ~squash;
        tail  <= rollback_idx + rob_idx_t'(1);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      entries[tail] <= '{dest: inst[0].dest, tag: renamed[0].tag,
                         told: renamed[0].told, halt: inst[0].halt};
      entries[tail_1] <= '{dest: inst[1].dest, tag: renamed[1].tag,
                           told: renamed[1].told, halt: inst[1].halt};
    end
  end

endmodule

//--- hw/rename_pkg.sv
package rename_pkg;

  // machine sizes
  localparam int num_super = 2;
  localparam int num_rob   = 16;
  localparam int num_arch  = 32;
  localparam int num_phys  = 48;

  typedef logic [$clog2(num_rob)-1:0]  rob_idx_t;
  typedef logic [$clog2(num_arch)-1:0] arch_reg_t;
  typedef logic [$clog2(num_phys)-1:0] phys_tag_t;

  // one instruction as seen at dispatch
  typedef struct packed {
    arch_reg_t dest;
    logic      halt;
  } dispatch_inst_t;

  // new tag plus the mapping it replaces
  typedef struct packed {
    phys_tag_t tag;
    phys_tag_t told;
  } rename_t;

  // rob payload, also what leaves at retire
  typedef struct packed {
    arch_reg_t dest;
    phys_tag_t tag;
    phys_tag_t told;
    logic      halt;
  } retire_t;

  // whole committed map, entry r holds the tag of register r
  typedef phys_tag_t [num_arch-1:0] arch_table_t;

  typedef enum logic [1:0] {
    running,
    recovering,
    halted
  } rob_state_t;

endpackage
